// File: src.f
hw/mipsPkg.sv
hw/stageReg.sv
hw/controlDecoder.sv
hw/hazardUnit.sv
hw/regFile.sv
hw/aluUnit.sv
hw/shiftUnit.sv
hw/executeStage.sv
hw/mipsCore.sv
tb/mipsCore_properties.sv
tb/mipsCore_tb.sv

// File: Makefile
SOURCES := $(shell cat src.f)

.PHONY: all run clean

all: run

obj_dir/VmipsCore_tb: src.f $(SOURCES)
	verilator --binary --assert --timescale 1ns/1ps -j 0 \
		--top-module mipsCore_tb -f src.f -o VmipsCore_tb

run: obj_dir/VmipsCore_tb
	@out=$$(./obj_dir/VmipsCore_tb 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// File: tb/mipsCore_tb.sv
module mipsCore_tb import mipsPkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumPrograms   = 4;
  localparam int TimeoutCycles = 200;

  typedef struct packed {
    wordT addr;
    wordT data;
  } storeT;

  logic  clk;
  logic  reset;
  wordT  pc;
  wordT  instr;
  logic  memWrite;
  wordT  dataAddr;
  wordT  writeData;
  wordT  readData;

  wordT  imem [256];
  wordT  dmem [256];
  wordT  programWords [$];    // Current row of the table
  storeT expectedStores [$];  // In program order

  mipsCore mipsCore_inst (
    .clk(clk), .reset(reset), .pc(pc), .instr(instr), .memWrite(memWrite),
    .dataAddr(dataAddr), .writeData(writeData), .readData(readData)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------
  // Memory models
  // --------------------------------------------------
  assign instr    = imem[pc[9:2]];
  assign readData = reset ? '0 : dmem[dataAddr[9:2]];  // Nothing valid in reset

  always @(posedge clk) begin
    if (reset) begin
      foreach (dmem[i]) begin
        dmem[i] <= '0;
      end
    end else if (memWrite) begin
      dmem[dataAddr[9:2]] <= writeData;
    end
  end

  // Instruction encoders
  function automatic wordT regOp(input int rs, input int rt, input int rd, input int shamt,
                                 input logic [5:0] funct);
    return {OpRType, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct};
  endfunction

  function automatic wordT immOp(input logic [5:0] op, input int rs, input int rt, input int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  function automatic wordT jumpTo(input int wordIndex);
    return {OpJ, wordIndex[25:0]};
  endfunction

  function automatic storeT storeAt(input wordT addr, input wordT data);
    return {addr, data};
  endfunction

  task automatic checkValue(input string name, input wordT actual, input wordT want);
    if (actual !== want) begin
      $display("CHECK FAILED at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, actual, want);
      $display("Simulation failed");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  // --------------------------------------------------
  // Program table
  // --------------------------------------------------
  task automatic loadProgram(input int row);
    case (row)
      0: begin  // Dependent ALU chain forwarding from memory and writeback
        programWords = '{
          immOp(OpAddi, 0, 1, 5),          immOp(OpAddi, 0, 2, -3),
          regOp(1, 2, 3, 0, FunctAdd),     regOp(3, 1, 4, 0, FunctSub),
          regOp(4, 1, 5, 0, FunctSlt),     regOp(4, 1, 6, 0, FunctSltu),
          regOp(4, 0, 7, 0, FunctNor),     immOp(OpLui, 0, 8, 'h1234),
          immOp(OpOri, 8, 8, 'hABCD),      regOp(8, 7, 9, 0, FunctXor),
          immOp(OpAndi, 9, 10, 'h00FF),    immOp(OpSltiu, 1, 11, -1),
          regOp(10, 11, 12, 0, FunctAddu), immOp(OpSw, 0, 3, 0),
          immOp(OpSw, 0, 4, 4),            immOp(OpSw, 0, 5, 8),
          immOp(OpSw, 0, 6, 12),           immOp(OpSw, 0, 7, 16),
          immOp(OpSw, 0, 9, 20),           immOp(OpSw, 0, 12, 24)};
        expectedStores = '{
          storeAt(0, 2),  storeAt(4, 32'hFFFF_FFFD), storeAt(8, 1), storeAt(12, 0),
          storeAt(16, 2), storeAt(20, 32'h1234_ABCF), storeAt(24, 32'h0000_00D0)};
      end
      1: begin  // $2 = 0x24, so variable shifts use 4
        programWords = '{
          immOp(OpAddi, 0, 1, 'hFF00),     immOp(OpAddi, 0, 2, 'h0024),
          regOp(0, 1, 3, 3, FunctSll),     regOp(0, 1, 4, 8, FunctSrl),
          regOp(0, 1, 5, 8, FunctSra),     regOp(2, 1, 6, 0, FunctSllv),
          regOp(2, 1, 7, 0, FunctSrlv),    regOp(2, 1, 8, 0, FunctSrav),
          immOp(OpSw, 0, 3, 0),            immOp(OpSw, 0, 4, 4),
          immOp(OpSw, 0, 5, 8),            immOp(OpSw, 0, 6, 12),
          immOp(OpSw, 0, 7, 16),           immOp(OpSw, 0, 8, 20)};
        expectedStores = '{
          storeAt(0, 32'hFFFF_F800),  storeAt(4, 32'h00FF_FFFF), storeAt(8, 32'hFFFF_FFFF),
          storeAt(12, 32'hFFFF_F000), storeAt(16, 32'h0FFF_FFF0), storeAt(20, 32'hFFFF_FFF0)};
      end
      2: begin  // Every load is used by the very next instruction
        programWords = '{
          immOp(OpAddi, 0, 1, 'h0040),     immOp(OpAddi, 0, 2, 'h1234),
          immOp(OpSw, 1, 2, 0),            immOp(OpLw, 1, 3, 0),
          immOp(OpAddi, 3, 4, 1),          immOp(OpSw, 1, 4, 4),
          immOp(OpLw, 1, 5, 4),            immOp(OpSw, 1, 5, 8),
          immOp(OpLw, 1, 6, 0),            regOp(6, 5, 7, 0, FunctAdd),
          immOp(OpSw, 1, 7, 12)};
        expectedStores = '{
          storeAt(32'h40, 32'h1234), storeAt(32'h44, 32'h1235),
          storeAt(32'h48, 32'h1235), storeAt(32'h4C, 32'h2469)};
      end
      3: begin
        // Delay slots always run while words 4, 13, 14 and 21 never do
        programWords = '{
          immOp(OpAddi, 0, 1, 7),          immOp(OpAddi, 0, 2, 7),
          immOp(OpBeq, 1, 2, 2),           immOp(OpAddi, 0, 3, 'h11),
          immOp(OpAddi, 0, 3, 'h22),       immOp(OpSw, 0, 3, 0),
          immOp(OpBne, 1, 2, 2),           immOp(OpAddi, 0, 4, 'h33),
          immOp(OpAddi, 4, 4, 1),          immOp(OpSw, 0, 4, 4),
          immOp(OpAddi, 0, 5, 3),          immOp(OpBne, 5, 1, 3),
          immOp(OpAddi, 0, 6, 'h55),       immOp(OpAddi, 0, 6, 'h66),
          immOp(OpSw, 0, 0, 8),            immOp(OpSw, 0, 6, 8),
          immOp(OpBeq, 5, 1, 2),           immOp(OpAddi, 6, 7, 1),
          immOp(OpAddi, 7, 7, 1),          jumpTo(22),
          immOp(OpSw, 0, 7, 12),           immOp(OpSw, 0, 0, 16),
          immOp(OpAddi, 0, 8, 'h77),       immOp(OpSw, 0, 8, 16)};
        expectedStores = '{
          storeAt(0, 32'h11), storeAt(4, 32'h34), storeAt(8, 32'h55),
          storeAt(12, 32'h57), storeAt(16, 32'h77)};
      end
      default: begin
        $display("Program table has no row %0d", row);
        $display("Simulation failed");
        $fatal(1, "Bad table row");
      end
    endcase
  endtask

  // --------------------------------------------------
  // Reset and store tracking
  // --------------------------------------------------
  task automatic resetCore();
    reset = 1'b1;
    foreach (imem[i]) begin
      imem[i] = (i < programWords.size()) ? programWords[i] : '0;
    end
    repeat (2) begin
      @(posedge clk);
      @(negedge clk);
      checkValue("memWrite", {31'b0, memWrite}, '0);
      checkValue("pc", pc, ResetPc);
    end
    reset = 1'b0;
  endtask

  task automatic awaitStore(input int row, input int idx, input storeT want);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!memWrite) begin
      if (cycles == TimeoutCycles) begin
        $display("Store %0d of program %0d never came within %0d cycles", idx, row,
                 TimeoutCycles);
        $display("Simulation failed");
        $fatal(1, "Store timeout");
      end
      cycles++;
      @(negedge clk);
    end
    checkValue($sformatf("dataAddr[%0d.%0d]", row, idx), dataAddr, want.addr);
    checkValue($sformatf("writeData[%0d.%0d]", row, idx), writeData, want.data);
  endtask

  initial begin
    reset = 1'b1;
    for (int row = 0; row < NumPrograms; row++) begin
      loadProgram(row);
      resetCore();
      foreach (expectedStores[i]) begin
        awaitStore(row, i, expectedStores[i]);
      end
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: tb/mipsCore_properties.sv
module mipsCoreProperties import mipsPkg::*; (
  input logic       clk,
  input logic       reset,
  input wordT       pc,
  input logic       memWrite,
  input logic       stall,
  input decodeExecT exec
);
  timeunit 1ns;
  timeprecision 1ps;

  // --------------------------------------------------
  // Store strobe and fetch address
  // --------------------------------------------------
  memWriteKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(memWrite))
    else $error("memWrite is unknown out of reset");

  pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("pc 0x%08h is not word aligned", pc);

  // --------------------------------------------------
  // Stall and flush
  // --------------------------------------------------
  pcHeldOnStall: assert property (@(posedge clk) disable iff (reset)
      stall |=> $stable(pc))
    else $error("pc moved during a stall");

  // A stalled decode leaves a bubble in execute
  flushIsBubble: assert property (@(posedge clk) disable iff (reset)
      stall |=> (!exec.ctrl.regWrite && !exec.ctrl.memWrite))
    else $error("Execute payload after a stall still has a write enabled");

endmodule

bind mipsCore mipsCoreProperties mipsCoreProps (
  .clk(clk),
  .reset(reset),
  .pc(pc),
  .memWrite(memWrite),
  .stall(stall),
  .exec(exec)
);

// File: hw/mipsCore.sv
module mipsCore import mipsPkg::*; (
  input  logic clk,
  input  logic reset,
  output wordT pc,
  input  wordT instr,
  output logic memWrite,
  output wordT dataAddr,
  output wordT writeData,
  input  wordT readData
);

  fetchDecodeT fetchNext, decode;
  decodeExecT  decodeNext, exec;
  execMemT     execOut, mem;
  memWbT       memNext, wb;
  ctrlT        decodeCtrl;
  fwdSelT      fwdExecA, fwdExecB;
  regAddrT     execWriteReg;
  regAddrT     rs, rt, rd;
  logic        stall, flushExec;
  logic        fwdDecodeA, fwdDecodeB;
  logic        takeBranch;
  wordT        pcPlus4, pcNext;
  wordT        rfA, rfB, cmpA, cmpB;
  wordT        imm, branchTarget, jumpTarget;
  wordT        wbResult;

  // --------------------------------------------------
  // Fetch
  // --------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= ResetPc;
    end else if (!stall) begin
      pc <= pcNext;
    end
  end

  assign pcPlus4   = pc + 32'd4;
  assign fetchNext = '{instr: instr, pcPlus4: pcPlus4};

  stageReg #(.payloadT(fetchDecodeT)) fetchDecodeReg (
    .clk(clk), .reset(reset), .enable(!stall), .clear(1'b0),
    .d(fetchNext), .q(decode)
  );

  // --------------------------------------------------
  // Decode and branch resolve
  // --------------------------------------------------
  assign rs = decode.instr[25:21];
  assign rt = decode.instr[20:16];
  assign rd = decode.instr[15:11];

  controlDecoder decoderInst (.instr(decode.instr), .ctrl(decodeCtrl));

  regFile regFileInst (
    .clk(clk), .writeEnable(wb.regWrite),
    .readAddrA(rs), .readAddrB(rt), .writeAddr(wb.writeReg),
    .writeData(wbResult), .readDataA(rfA), .readDataB(rfB)
  );

  assign imm = decodeCtrl.zeroExt ? {16'b0, decode.instr[15:0]}
                                  : {{16{decode.instr[15]}}, decode.instr[15:0]};

  assign cmpA = fwdDecodeA ? mem.aluOut : rfA;
  assign cmpB = fwdDecodeB ? mem.aluOut : rfB;

  // Targets are relative to the delay slot
  assign branchTarget = decode.pcPlus4 + {imm[29:0], 2'b00};
  assign jumpTarget   = {decode.pcPlus4[31:28], decode.instr[25:0], 2'b00};
  assign takeBranch   = decodeCtrl.branch && ((cmpA == cmpB) != decodeCtrl.branchNe);

  always_comb begin
    if (decodeCtrl.jump) pcNext = jumpTarget;
    else if (takeBranch) pcNext = branchTarget;
    else pcNext = pcPlus4;
  end

  assign decodeNext = '{ctrl: decodeCtrl, srcA: rfA, srcB: rfB, imm: imm,
                        rs: rs, rt: rt, rd: rd};

  hazardUnit hazardInst (
    .decode(decode), .decodeCtrl(decodeCtrl), .exec(exec),
    .execWriteReg(execWriteReg), .mem(mem), .wb(wb),
    .fwdDecodeA(fwdDecodeA), .fwdDecodeB(fwdDecodeB),
    .fwdExecA(fwdExecA), .fwdExecB(fwdExecB),
    .stall(stall), .flushExec(flushExec)
  );

  stageReg #(.payloadT(decodeExecT)) decodeExecReg (
    .clk(clk), .reset(reset), .enable(1'b1), .clear(flushExec),
    .d(decodeNext), .q(exec)
  );

  // --------------------------------------------------
  // Execute, memory, writeback
  // --------------------------------------------------
  executeStage executeInst (
    .exec(exec), .fwdA(fwdExecA), .fwdB(fwdExecB),
    .memAluOut(mem.aluOut), .wbResult(wbResult),
    .execWriteReg(execWriteReg), .out(execOut)
  );

  stageReg #(.payloadT(execMemT)) execMemReg (
    .clk(clk), .reset(reset), .enable(1'b1), .clear(1'b0),
    .d(execOut), .q(mem)
  );

  assign memWrite  = mem.memWrite;
  assign dataAddr  = mem.aluOut;
  assign writeData = mem.writeData;

  assign memNext = '{regWrite: mem.regWrite, memToReg: mem.memToReg, aluOut: mem.aluOut,
                     readData: readData, writeReg: mem.writeReg};

  stageReg #(.payloadT(memWbT)) memWbReg (
    .clk(clk), .reset(reset), .enable(1'b1), .clear(1'b0),
    .d(memNext), .q(wb)
  );

  assign wbResult = wb.memToReg ? wb.readData : wb.aluOut;   // Load or ALU result

endmodule

// File: hw/executeStage.sv
module executeStage import mipsPkg::*; (
  input  decodeExecT exec,
  input  fwdSelT     fwdA,
  input  fwdSelT     fwdB,
  input  wordT       memAluOut,
  input  wordT       wbResult,
  output regAddrT    execWriteReg,
  output execMemT    out
);

  wordT srcA;
  wordT srcB;
  wordT operandB;
  wordT aluResult;
  wordT shiftResult;

  function automatic wordT pickOperand(input fwdSelT sel, input wordT regValue);
    case (sel)
      FwdMem:  return memAluOut;
      FwdWb:   return wbResult;
      default: return regValue;
    endcase
  endfunction

  always_comb begin
    srcA = pickOperand(fwdA, exec.srcA);
    srcB = pickOperand(fwdB, exec.srcB);
  end

  assign operandB = exec.ctrl.aluSrc ? exec.imm : srcB;

  aluUnit aluInst (
    .a      (srcA),
    .b      (operandB),
    .op     (exec.ctrl.aluOp),
    .result (aluResult)
  );

  shiftUnit shiftInst (
    .a      (srcA),
    .b      (operandB),
    .op     (exec.ctrl.shiftOp),
    .lui    (exec.ctrl.lui),
    .shamt  (exec.imm[10:6]),   // shamt field survives the extension
    .result (shiftResult)
  );

  assign execWriteReg = exec.ctrl.regDst ? exec.rd : exec.rt;

  assign out.regWrite  = exec.ctrl.regWrite;
  assign out.memToReg  = exec.ctrl.memToReg;
  assign out.memWrite  = exec.ctrl.memWrite;
  assign out.aluOut    = exec.ctrl.useShift ? shiftResult : aluResult;
  assign out.writeData = srcB;                // Store data after forwarding
  assign out.writeReg  = execWriteReg;

endmodule

// File: hw/shiftUnit.sv
module shiftUnit import mipsPkg::*; (
  input  wordT       a,
  input  wordT       b,
  input  shiftOpT    op,
  input  logic       lui,
  input  logic [4:0] shamt,
  output wordT       result
);

  logic [4:0] amount;

  always_comb begin
    if (lui) begin
      amount = 5'd16;
    end else if (op.constAmount) begin
      amount = shamt;               // SLL, SRL, SRA
    end else begin
      amount = a[4:0];              // Variable forms take rs
    end
  end

  always_comb begin
    if (op.left) begin
      result = b << amount;
    end else if (op.arith) begin
      result = $signed(b) >>> amount;
    end else begin
      result = b >> amount;
    end
  end

endmodule

// File: hw/aluUnit.sv
module aluUnit import mipsPkg::*; (
  input  wordT  a,
  input  wordT  b,
  input  aluOpT op,
  output wordT  result
);

  logic subtract;
  wordT bAdj;
  wordT sum;
  logic lessSigned;
  logic lessUnsigned;

  // Shared adder, b inverted plus carry-in for sub and slt
  assign subtract = (op == AluSub) || (op == AluSlt);
  assign bAdj     = subtract ? ~b : b;
  assign sum      = a + bAdj + {31'b0, subtract};

  // Differing signs decide without the difference
  assign lessSigned   = (a[31] != b[31]) ? a[31] : sum[31];
  assign lessUnsigned = (a < b);

  always_comb begin
    case (op)
      AluAnd:  result = a & b;
      AluOr:   result = a | b;
      AluXor:  result = a ^ b;
      AluNor:  result = ~(a | b);
      AluSlt:  result = {31'b0, lessSigned};
      AluSltu: result = {31'b0, lessUnsigned};
      default: result = sum;        // add, sub
    endcase
  end

endmodule

// File: hw/regFile.sv
module regFile import mipsPkg::*; (
  input  logic    clk,
  input  logic    writeEnable,
  input  regAddrT readAddrA,
  input  regAddrT readAddrB,
  input  regAddrT writeAddr,
  input  wordT    writeData,
  output wordT    readDataA,
  output wordT    readDataB
);

  wordT regs [32];

  // Falling edge write, so decode sees it in the same cycle
  always_ff @(negedge clk) begin
    if (writeEnable) begin
      regs[writeAddr] <= writeData;
    end
  end

  assign readDataA = (readAddrA != '0) ? regs[readAddrA] : '0;  // $0 is hardwired
  assign readDataB = (readAddrB != '0) ? regs[readAddrB] : '0;

endmodule

// File: hw/hazardUnit.sv
module hazardUnit import mipsPkg::*; (
  input  fetchDecodeT decode,
  input  ctrlT        decodeCtrl,
  input  decodeExecT  exec,
  input  regAddrT     execWriteReg,
  input  execMemT     mem,
  input  memWbT       wb,
  output logic        fwdDecodeA,
  output logic        fwdDecodeB,
  output fwdSelT      fwdExecA,
  output fwdSelT      fwdExecB,
  output logic        stall,
  output logic        flushExec
);

  regAddrT rsD;
  regAddrT rtD;
  logic    loadUse;
  logic    branchStall;

  assign rsD = decode.instr[25:21];
  assign rtD = decode.instr[20:16];

  // Branch compare only takes the ALU result sitting in memory
  assign fwdDecodeA = (rsD != '0) && mem.regWrite && (rsD == mem.writeReg);
  assign fwdDecodeB = (rtD != '0) && mem.regWrite && (rtD == mem.writeReg);

  // Memory stage wins over writeback
  always_comb begin
    fwdExecA = FwdNone;
    fwdExecB = FwdNone;
    if (exec.rs != '0) begin
      if (mem.regWrite && exec.rs == mem.writeReg) fwdExecA = FwdMem;
      else if (wb.regWrite && exec.rs == wb.writeReg) fwdExecA = FwdWb;
    end
    if (exec.rt != '0) begin
      if (mem.regWrite && exec.rt == mem.writeReg) fwdExecB = FwdMem;
      else if (wb.regWrite && exec.rt == wb.writeReg) fwdExecB = FwdWb;
    end
  end

  // --------------------------------------------------
  // Stalls
  // --------------------------------------------------
  assign loadUse = exec.ctrl.memToReg && (exec.rt != '0) &&
                   (exec.rt == rsD || exec.rt == rtD);

  assign branchStall = decodeCtrl.branch &&
    ((exec.ctrl.regWrite && execWriteReg != '0 &&
      (execWriteReg == rsD || execWriteReg == rtD)) ||
     (mem.memToReg && mem.writeReg != '0 &&
      (mem.writeReg == rsD || mem.writeReg == rtD)));

  assign stall     = loadUse || branchStall;
  assign flushExec = stall;   // Bubble into execute while decode holds

endmodule

// File: hw/controlDecoder.sv
module controlDecoder import mipsPkg::*; (
  input  wordT instr,
  output ctrlT ctrl
);

  logic [5:0] op;
  logic [5:0] funct;

  assign op    = instr[31:26];
  assign funct = instr[5:0];

  always_comb begin
    ctrl       = '0;              // Anything unknown falls through as a no-op
    ctrl.aluOp = AluAdd;

    case (op)
      OpRType: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = 1'b1;
        case (funct)
          FunctAdd, FunctAddu: ctrl.aluOp = AluAdd;
          FunctSub, FunctSubu: ctrl.aluOp = AluSub;
          FunctAnd:            ctrl.aluOp = AluAnd;
          FunctOr:             ctrl.aluOp = AluOr;
          FunctXor:            ctrl.aluOp = AluXor;
          FunctNor:            ctrl.aluOp = AluNor;
          FunctSlt:            ctrl.aluOp = AluSlt;
          FunctSltu:           ctrl.aluOp = AluSltu;
          FunctSll, FunctSrl, FunctSra, FunctSllv, FunctSrlv, FunctSrav: begin
            // funct[2] marks the variable forms, funct[1:0] the direction
            ctrl.useShift            = 1'b1;
            ctrl.shiftOp.constAmount = ~funct[2];
            ctrl.shiftOp.left        = (funct[1:0] == 2'b00);
            ctrl.shiftOp.arith       = (funct[1:0] == 2'b11);
          end
          default: begin
            ctrl.regWrite = 1'b0;
            ctrl.regDst   = 1'b0;
          end
        endcase
      end

      OpAddi, OpAddiu: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
      end
      OpSlti, OpSltiu: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = (op == OpSlti) ? AluSlt : AluSltu;  // Both sign-extend
      end
      OpAndi, OpOri, OpXori: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.zeroExt  = 1'b1;
        ctrl.aluOp    = (op == OpAndi) ? AluAnd : ((op == OpOri) ? AluOr : AluXor);
      end
      OpLui: begin
        ctrl.regWrite     = 1'b1;
        ctrl.aluSrc       = 1'b1;
        ctrl.zeroExt      = 1'b1;
        ctrl.useShift     = 1'b1;
        ctrl.lui          = 1'b1;   // Shifter moves imm up by 16
        ctrl.shiftOp.left = 1'b1;
      end

      OpLw: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
      end
      OpSw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
      end

      OpBeq: ctrl.branch = 1'b1;
      OpBne: begin
        ctrl.branch   = 1'b1;
        ctrl.branchNe = 1'b1;
      end
      OpJ: ctrl.jump = 1'b1;

      default: ctrl.aluOp = AluAdd;
    endcase
  end

endmodule

// File: hw/stageReg.sv
module stageReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    enable,
  input  logic    clear,
  input  payloadT d,
  output payloadT q
);

  // Clear turns the stage into a bubble
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      q <= '0;
    end else if (clear) begin
      q <= '0;
    end else if (enable) begin
      q <= d;
    end
  end

endmodule

// File: hw/mipsPkg.sv
package mipsPkg;

  typedef logic [31:0] wordT;
  typedef logic [4:0]  regAddrT;

  // --------------------------------------------------
  // Opcode field in instr[31:26]
  // --------------------------------------------------
  localparam logic [5:0] OpRType = 6'b000000;
  localparam logic [5:0] OpJ     = 6'b000010;
  localparam logic [5:0] OpBeq   = 6'b000100;
  localparam logic [5:0] OpBne   = 6'b000101;
  localparam logic [5:0] OpAddi  = 6'b001000;
  localparam logic [5:0] OpAddiu = 6'b001001;
  localparam logic [5:0] OpSlti  = 6'b001010;
  localparam logic [5:0] OpSltiu = 6'b001011;
  localparam logic [5:0] OpAndi  = 6'b001100;
  localparam logic [5:0] OpOri   = 6'b001101;
  localparam logic [5:0] OpXori  = 6'b001110;
  localparam logic [5:0] OpLui   = 6'b001111;
  localparam logic [5:0] OpLw    = 6'b100011;
  localparam logic [5:0] OpSw    = 6'b101011;

  // Funct field for R-types
  localparam logic [5:0] FunctSll  = 6'b000000;
  localparam logic [5:0] FunctSrl  = 6'b000010;
  localparam logic [5:0] FunctSra  = 6'b000011;
  localparam logic [5:0] FunctSllv = 6'b000100;
  localparam logic [5:0] FunctSrlv = 6'b000110;
  localparam logic [5:0] FunctSrav = 6'b000111;
  localparam logic [5:0] FunctAdd  = 6'b100000;
  localparam logic [5:0] FunctAddu = 6'b100001;
  localparam logic [5:0] FunctSub  = 6'b100010;
  localparam logic [5:0] FunctSubu = 6'b100011;
  localparam logic [5:0] FunctAnd  = 6'b100100;
  localparam logic [5:0] FunctOr   = 6'b100101;
  localparam logic [5:0] FunctXor  = 6'b100110;
  localparam logic [5:0] FunctNor  = 6'b100111;
  localparam logic [5:0] FunctSlt  = 6'b101010;
  localparam logic [5:0] FunctSltu = 6'b101011;

  localparam wordT ResetPc = 32'h0000_0000;

  // --------------------------------------------------
  // Control and stage payloads
  // --------------------------------------------------
  typedef enum logic [2:0] {
    AluAnd  = 3'b000,
    AluOr   = 3'b001,
    AluAdd  = 3'b010,
    AluSltu = 3'b011,
    AluXor  = 3'b100,
    AluNor  = 3'b101,
    AluSub  = 3'b110,   // Adder with inverted b
    AluSlt  = 3'b111
  } aluOpT;

  typedef struct packed {
    logic constAmount;  // Amount from shamt field
    logic left;
    logic arith;
  } shiftOpT;

  typedef struct packed {
    logic    regWrite;
    logic    regDst;    // Write rd instead of rt
    logic    aluSrc;    // Immediate as operand B
    logic    memWrite;
    logic    memToReg;
    logic    useShift;
    aluOpT   aluOp;
    shiftOpT shiftOp;
    logic    zeroExt;
    logic    lui;
    logic    branch;
    logic    branchNe;
    logic    jump;
  } ctrlT;

  typedef struct packed {
    wordT instr;
    wordT pcPlus4;
  } fetchDecodeT;

  typedef struct packed {
    ctrlT    ctrl;
    wordT    srcA;
    wordT    srcB;
    wordT    imm;
    regAddrT rs;
    regAddrT rt;
    regAddrT rd;
  } decodeExecT;

  typedef struct packed {
    logic    regWrite;
    logic    memToReg;
    logic    memWrite;
    wordT    aluOut;
    wordT    writeData;
    regAddrT writeReg;
  } execMemT;

  typedef struct packed {
    logic    regWrite;
    logic    memToReg;
    wordT    aluOut;
    wordT    readData;
    regAddrT writeReg;
  } memWbT;

  typedef enum logic [1:0] {
    FwdNone = 2'b00,
    FwdWb   = 2'b01,
    FwdMem  = 2'b10
  } fwdSelT;

endpackage
